// File: hdl/mpeg_sys_pkg.sv
/*
 * Shared field types and start code constants for the MPEG-1 system
 * stream header parser. Every stage imports this package; field widths
 * follow the MPEG-1 system layer syntax.
 */

package mpeg_sys_pkg;

	// one byte of the incoming stream
	typedef logic [7:0] byte_t;

	// 90 kHz system clock reference
	typedef logic [32:0] scr_t;

	// mux rate and rate bound, units of 50 bytes/s
	typedef logic [21:0] rate_t;

	// system header length, counts bytes after the length field
	typedef logic [15:0] hdr_len_t;

	typedef logic [7:0] stream_id_t;

	// std buffer size bound, in 128 or 1024 byte units by scale
	typedef logic [12:0] buf_size_t;

	// last byte of each recognised start code, after 00 00 01
	localparam byte_t PACK_START_CODE          = 8'hBA;
	localparam byte_t SYSTEM_HEADER_START_CODE = 8'hBB;

	// fixed pack header size after the code
	localparam int PACK_HEADER_BYTES = 8;

	// system header bytes between the length field and the stream entries
	localparam int SYS_FIXED_BYTES = 6;

endpackage

// File: hdl/serial_byte_assembler.sv
/*
 * Collects the serial stream into bytes, most significant bit first.
 * stream_bit is taken only on cycles with en high; gaps in en simply
 * hold the partial byte. byte_valid pulses for one cycle once the
 * eighth bit of a byte has been shifted in.
 */

`timescale 1ns/1ps

module serial_byte_assembler (
	input  logic                clk,
	input  logic                reset,
	input  logic                en,
	input  logic                stream_bit,
	output mpeg_sys_pkg::byte_t byte_data,
	output logic                byte_valid
);

	logic [6:0] shift_reg; // first seven bits of the current byte
	logic [2:0] bit_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt    <= '0;
			byte_valid <= 1'b0;
			byte_data  <= '0;
		end else begin
			byte_valid <= 1'b0;
			if (en) begin
				bit_cnt <= bit_cnt + 3'd1; // wraps to 0 after bit 7
				if (bit_cnt == 3'd7) begin
					byte_data  <= {shift_reg, stream_bit};
					byte_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (en)
			shift_reg <= {shift_reg[5:0], stream_bit};
	end

endmodule

// File: hdl/start_code_detector.sv
/*
 * Hunts for the 00 00 01 start code prefix and, on a pack or system
 * header code, forwards the following bytes to that header's parser.
 * Forwarding is combinational with byte_valid. No hunting is done while
 * forwarding, so code-like bytes inside a header stay payload.
 */

`timescale 1ns/1ps

module start_code_detector (
	input  logic                clk,
	input  logic                reset,
	input  mpeg_sys_pkg::byte_t byte_data,
	input  logic                byte_valid,
	input  logic                pack_done,
	input  logic                sys_end,
	output logic                pack_byte_valid,
	output logic                sys_byte_valid
);

	import mpeg_sys_pkg::*;

	typedef enum logic [2:0] {
		hunt_zero,  // no prefix bytes seen
		hunt_zero2, // one 00 seen
		hunt_one,   // 00 00 seen, waiting for 01
		hunt_code,  // full prefix seen
		fwd_pack,
		fwd_sys
	} state_t;

	state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= hunt_zero;
		end else begin
			case (state)
				hunt_zero: begin
					if (byte_valid && byte_data == 8'h00)
						state <= hunt_zero2;
				end
				hunt_zero2: begin
					if (byte_valid)
						state <= (byte_data == 8'h00) ? hunt_one : hunt_zero;
				end
				hunt_one: begin
					if (byte_valid) begin
						if (byte_data == 8'h01)
							state <= hunt_code;
						else if (byte_data != 8'h00) // extra zeros keep the prefix alive
							state <= hunt_zero;
					end
				end
				hunt_code: begin
					if (byte_valid) begin
						if (byte_data == PACK_START_CODE)
							state <= fwd_pack;
						else if (byte_data == SYSTEM_HEADER_START_CODE)
							state <= fwd_sys;
						else if (byte_data == 8'h00) // may open the next prefix
							state <= hunt_zero2;
						else
							state <= hunt_zero; // foreign code, drop it
					end
				end
				fwd_pack: begin
					if (pack_done)
						state <= hunt_zero;
				end
				fwd_sys: begin
					if (sys_end) // done or abort
						state <= hunt_zero;
				end
				default: state <= hunt_zero;
			endcase
		end
	end

	assign pack_byte_valid = byte_valid && (state == fwd_pack);
	assign sys_byte_valid  = byte_valid && (state == fwd_sys);

endmodule

// File: hdl/pack_header_parser.sv
/*
 * Unpacks the eight pack header bytes that follow a pack start code.
 * The SCR spans bytes 0 to 4 and the mux rate bytes 5 to 7, with marker
 * bits in between. All fields are published together with a one cycle
 * pack_done pulse after the eighth byte.
 */

`timescale 1ns/1ps

module pack_header_parser (
	input  logic                clk,
	input  logic                reset,
	input  mpeg_sys_pkg::byte_t byte_data,
	input  logic                pack_byte_valid,
	output mpeg_sys_pkg::scr_t  scr,
	output mpeg_sys_pkg::rate_t mux_rate,
	output logic                marker_error,
	output logic                pack_done
);

	import mpeg_sys_pkg::*;

	logic [2:0]  byte_idx;
	logic        marker_bad; // any marker seen so far was 0
	scr_t        scr_acc;
	logic [21:7] mux_acc;    // low 7 bits come with the last byte

	always_ff @(posedge clk) begin
		if (reset) begin
			byte_idx     <= '0;
			marker_bad   <= 1'b0;
			pack_done    <= 1'b0;
			scr          <= '0;
			mux_rate     <= '0;
			marker_error <= 1'b0;
		end else begin
			pack_done <= 1'b0;
			if (pack_byte_valid) begin
				case (byte_idx)
					3'd0:       marker_bad <= ~byte_data[0]; // new header, restart check
					3'd2, 3'd4: marker_bad <= marker_bad | ~byte_data[0];
					3'd5:       marker_bad <= marker_bad | ~byte_data[7];
					default:    ;
				endcase
				if (byte_idx == 3'(PACK_HEADER_BYTES - 1)) begin
					byte_idx     <= '0;
					pack_done    <= 1'b1;
					scr          <= scr_acc;
					mux_rate     <= {mux_acc, byte_data[7:1]};
					marker_error <= marker_bad | ~byte_data[0];
				end else begin
					byte_idx <= byte_idx + 3'd1;
				end
			end
		end
	end

	// field bits; byte 0 upper nibble is the 0010 pattern and is not kept
	always_ff @(posedge clk) begin
		if (pack_byte_valid) begin
			case (byte_idx)
				3'd0:    scr_acc[32:30] <= byte_data[3:1];
				3'd1:    scr_acc[29:22] <= byte_data;
				3'd2:    scr_acc[21:15] <= byte_data[7:1];
				3'd3:    scr_acc[14:7]  <= byte_data;
				3'd4:    scr_acc[6:0]   <= byte_data[7:1];
				3'd5:    mux_acc[21:15] <= byte_data[6:0];
				3'd6:    mux_acc[14:7]  <= byte_data;
				default: ;
			endcase
		end
	end

endmodule

// File: hdl/system_header_parser.sv
/*
 * Parses the system header that follows a system header start code.
 * Reads the length field and the six fixed bytes, pulses sys_done with
 * the bounds and flags, then reports each 3-byte stream entry with
 * entry_valid until the length is used up. An inconsistent length or a
 * bad entry gives sys_abort. sys_end marks either way out.
 */

`timescale 1ns/1ps

module system_header_parser (
	input  logic                      clk,
	input  logic                      reset,
	input  mpeg_sys_pkg::byte_t       byte_data,
	input  logic                      sys_byte_valid,
	output mpeg_sys_pkg::rate_t       rate_bound,
	output logic [5:0]                audio_bound,
	output logic [4:0]                video_bound,
	output logic [3:0]                sys_flags,
	output logic                      sys_done,
	output mpeg_sys_pkg::stream_id_t  entry_stream_id,
	output logic                      entry_buf_scale,
	output mpeg_sys_pkg::buf_size_t   entry_buf_size,
	output logic                      entry_valid,
	output logic                      sys_abort,
	output logic                      sys_end
);

	import mpeg_sys_pkg::*;

	typedef enum logic [2:0] {len_hi, len_lo, fixed, entry, idle} state_t;

	state_t     state;
	logic [2:0] byte_idx;  // fixed byte 0..5 or entry byte 0..2
	hdr_len_t   remaining; // bytes left in the header
	hdr_len_t   rem_next;
	hdr_len_t   len_word;
	byte_t      len_hi_byte;
	rate_t      rate_acc;
	logic [5:0] audio_acc;
	logic [4:0] video_acc;
	logic [3:0] flag_acc;  // fixed, csps, audio lock, video lock
	stream_id_t id_acc;
	logic       scale_acc;
	logic [4:0] size_hi_acc;

	assign rem_next = remaining - 16'd1;
	assign len_word = {len_hi_byte, byte_data};

	always_ff @(posedge clk) begin
		if (reset) begin
			state           <= idle;
			byte_idx        <= '0;
			remaining       <= '0;
			sys_done        <= 1'b0;
			entry_valid     <= 1'b0;
			sys_abort       <= 1'b0;
			sys_end         <= 1'b0;
			rate_bound      <= '0;
			audio_bound     <= '0;
			video_bound     <= '0;
			sys_flags       <= '0;
			entry_stream_id <= '0;
			entry_buf_scale <= 1'b0;
			entry_buf_size  <= '0;
		end else begin
			sys_done    <= 1'b0;
			entry_valid <= 1'b0;
			sys_abort   <= 1'b0;
			sys_end     <= 1'b0;
			case (state)
				idle: begin
					byte_idx <= '0; // rearm for the next header
					state    <= len_hi;
				end
				len_hi: begin
					if (sys_byte_valid)
						state <= len_lo;
				end
				len_lo: begin
					if (sys_byte_valid) begin
						byte_idx <= '0;
						if (len_word < SYS_FIXED_BYTES) begin // too short for fixed part
							sys_abort <= 1'b1;
							sys_end   <= 1'b1;
							state     <= idle;
						end else begin
							remaining <= len_word;
							state     <= fixed;
						end
					end
				end
				fixed: begin
					if (sys_byte_valid) begin
						remaining <= rem_next;
						if (byte_idx == 3'(SYS_FIXED_BYTES - 1)) begin
							byte_idx    <= '0;
							sys_done    <= 1'b1;
							rate_bound  <= rate_acc;
							audio_bound <= audio_acc;
							video_bound <= video_acc;
							sys_flags   <= flag_acc;
							if (rem_next == '0) begin // header without entries
								sys_end <= 1'b1;
								state   <= idle;
							end else if ((rem_next % 16'd3) != 16'd0) begin
								sys_abort <= 1'b1;
								sys_end   <= 1'b1;
								state     <= idle;
							end else begin
								state <= entry;
							end
						end else begin
							byte_idx <= byte_idx + 3'd1;
						end
					end
				end
				entry: begin
					if (sys_byte_valid) begin
						remaining <= rem_next;
						case (byte_idx)
							3'd0: begin
								if (!byte_data[7]) begin // not a stream id
									sys_abort <= 1'b1;
									sys_end   <= 1'b1;
									state     <= idle;
								end else begin
									byte_idx <= 3'd1;
								end
							end
							3'd1: byte_idx <= 3'd2;
							default: begin
								byte_idx        <= '0;
								entry_valid     <= 1'b1;
								entry_stream_id <= id_acc;
								entry_buf_scale <= scale_acc;
								entry_buf_size  <= {size_hi_acc, byte_data};
								if (rem_next == '0) begin
									sys_end <= 1'b1;
									state   <= idle;
								end
							end
						endcase
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// partial fields; marker bits and the reserved byte are skipped
	always_ff @(posedge clk) begin
		if (sys_byte_valid) begin
			case (state)
				len_hi: len_hi_byte <= byte_data;
				fixed: begin
					case (byte_idx)
						3'd0: rate_acc[21:15] <= byte_data[6:0];
						3'd1: rate_acc[14:7]  <= byte_data;
						3'd2: rate_acc[6:0]   <= byte_data[7:1];
						3'd3: begin
							audio_acc     <= byte_data[7:2];
							flag_acc[3:2] <= byte_data[1:0];
						end
						3'd4: begin
							flag_acc[1:0] <= byte_data[7:6];
							video_acc     <= byte_data[4:0];
						end
						default: ;
					endcase
				end
				entry: begin
					case (byte_idx)
						3'd0: id_acc <= byte_data;
						3'd1: begin
							scale_acc   <= byte_data[5]; // top two bits are 11
							size_hi_acc <= byte_data[4:0];
						end
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

// File: hdl/mpeg_sys_parser.sv
/*
 * Top level of the MPEG-1 system stream header parser. Serial bits go
 * through the byte assembler and the start code detector into the pack
 * and system header parsers, whose results are the outputs here.
 */

`timescale 1ns/1ps

module mpeg_sys_parser (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      en,
	input  logic                      stream_bit,
	output mpeg_sys_pkg::scr_t        scr,
	output mpeg_sys_pkg::rate_t       mux_rate,
	output logic                      marker_error,
	output logic                      pack_done,
	output mpeg_sys_pkg::rate_t       rate_bound,
	output logic [5:0]                audio_bound,
	output logic [4:0]                video_bound,
	output logic [3:0]                sys_flags,
	output logic                      sys_done,
	output mpeg_sys_pkg::stream_id_t  entry_stream_id,
	output logic                      entry_buf_scale,
	output mpeg_sys_pkg::buf_size_t   entry_buf_size,
	output logic                      entry_valid,
	output logic                      sys_abort
);

	import mpeg_sys_pkg::*;

	byte_t byte_data;
	logic  byte_valid;
	logic  pack_byte_valid;
	logic  sys_byte_valid;
	logic  sys_end; // system parser finished or gave up

	serial_byte_assembler i_serial_byte_assembler (
		.clk        (clk),
		.reset      (reset),
		.en         (en),
		.stream_bit (stream_bit),
		.byte_data  (byte_data),
		.byte_valid (byte_valid)
	);

	start_code_detector i_start_code_detector (
		.clk             (clk),
		.reset           (reset),
		.byte_data       (byte_data),
		.byte_valid      (byte_valid),
		.pack_done       (pack_done),
		.sys_end         (sys_end),
		.pack_byte_valid (pack_byte_valid),
		.sys_byte_valid  (sys_byte_valid)
	);

	pack_header_parser i_pack_header_parser (
		.clk             (clk),
		.reset           (reset),
		.byte_data       (byte_data),
		.pack_byte_valid (pack_byte_valid),
		.scr             (scr),
		.mux_rate        (mux_rate),
		.marker_error    (marker_error),
		.pack_done       (pack_done)
	);

	system_header_parser i_system_header_parser (
		.clk             (clk),
		.reset           (reset),
		.byte_data       (byte_data),
		.sys_byte_valid  (sys_byte_valid),
		.rate_bound      (rate_bound),
		.audio_bound     (audio_bound),
		.video_bound     (video_bound),
		.sys_flags       (sys_flags),
		.sys_done        (sys_done),
		.entry_stream_id (entry_stream_id),
		.entry_buf_scale (entry_buf_scale),
		.entry_buf_size  (entry_buf_size),
		.entry_valid     (entry_valid),
		.sys_abort       (sys_abort),
		.sys_end         (sys_end)
	);

endmodule

// File: sim/tb_mpeg_sys_parser.sv
/*
 * Testbench for the MPEG-1 system stream header parser. Builds pack and
 * system headers from chosen field values, serializes them MSB first
 * with random en gaps, and checks every result pulse against queues of
 * expected values. Run with mpeg_sys_parser.f as top tb_mpeg_sys_parser.
 */

`timescale 1ns/1ps

module tb_mpeg_sys_parser;

	import mpeg_sys_pkg::*;

	logic clk;
	logic reset;
	logic en;
	logic stream_bit;
	scr_t scr;
	rate_t mux_rate;
	logic marker_error;
	logic pack_done;
	rate_t rate_bound;
	logic [5:0] audio_bound;
	logic [4:0] video_bound;
	logic [3:0] sys_flags;
	logic sys_done;
	stream_id_t entry_stream_id;
	logic entry_buf_scale;
	buf_size_t entry_buf_size;
	logic entry_valid;
	logic sys_abort;

	int seed;
	byte_t tx_q[$];        // bytes waiting to be serialized
	scr_t exp_scr_q[$];
	rate_t exp_mux_q[$];
	logic exp_mkr_q[$];
	rate_t exp_rate_q[$];
	logic [5:0] exp_audio_q[$];
	logic [4:0] exp_video_q[$];
	logic [3:0] exp_flags_q[$];
	stream_id_t exp_id_q[$];
	logic exp_scale_q[$];
	buf_size_t exp_size_q[$];
	int abort_expected;

	mpeg_sys_parser i_mpeg_sys_parser (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] want);
		$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, want);
		abort_run("output value differs from the reference decode");
	endtask

	function automatic int pending();
		return exp_scr_q.size() + exp_rate_q.size() + exp_id_q.size() + abort_expected;
	endfunction

	// every result strobe is a single cycle pulse
	assert property (@(posedge clk) disable iff (reset) pack_done |=> !pack_done)
		else abort_run("pack_done held longer than one cycle");
	assert property (@(posedge clk) disable iff (reset) sys_done |=> !sys_done)
		else abort_run("sys_done held longer than one cycle");
	assert property (@(posedge clk) disable iff (reset) entry_valid |=> !entry_valid)
		else abort_run("entry_valid held longer than one cycle");
	assert property (@(posedge clk) disable iff (reset) sys_abort |-> !entry_valid)
		else abort_run("entry_valid together with sys_abort");

	always @(posedge clk) begin
		if (!reset) begin
			if (pack_done) begin
				if (exp_scr_q.size() == 0)
					abort_run("pack_done without a pack header in the stream");
				assert (scr == exp_scr_q[0]) else mismatch("scr", 64'(scr), 64'(exp_scr_q[0]));
				assert (mux_rate == exp_mux_q[0])
					else mismatch("mux_rate", 64'(mux_rate), 64'(exp_mux_q[0]));
				assert (marker_error == exp_mkr_q[0])
					else mismatch("marker_error", 64'(marker_error), 64'(exp_mkr_q[0]));
				exp_scr_q.delete(0);
				exp_mux_q.delete(0);
				exp_mkr_q.delete(0);
			end
			if (sys_done) begin
				if (exp_rate_q.size() == 0)
					abort_run("sys_done without a system header in the stream");
				assert (rate_bound == exp_rate_q[0])
					else mismatch("rate_bound", 64'(rate_bound), 64'(exp_rate_q[0]));
				assert (audio_bound == exp_audio_q[0])
					else mismatch("audio_bound", 64'(audio_bound), 64'(exp_audio_q[0]));
				assert (video_bound == exp_video_q[0])
					else mismatch("video_bound", 64'(video_bound), 64'(exp_video_q[0]));
				assert (sys_flags == exp_flags_q[0])
					else mismatch("sys_flags", 64'(sys_flags), 64'(exp_flags_q[0]));
				exp_rate_q.delete(0);
				exp_audio_q.delete(0);
				exp_video_q.delete(0);
				exp_flags_q.delete(0);
			end
			if (entry_valid) begin
				if (exp_id_q.size() == 0)
					abort_run("entry_valid with no stream entry outstanding");
				assert (entry_stream_id == exp_id_q[0])
					else mismatch("entry_stream_id", 64'(entry_stream_id), 64'(exp_id_q[0]));
				assert (entry_buf_scale == exp_scale_q[0])
					else mismatch("entry_buf_scale", 64'(entry_buf_scale), 64'(exp_scale_q[0]));
				assert (entry_buf_size == exp_size_q[0])
					else mismatch("entry_buf_size", 64'(entry_buf_size), 64'(exp_size_q[0]));
				exp_id_q.delete(0);
				exp_scale_q.delete(0);
				exp_size_q.delete(0);
			end
			if (sys_abort) begin
				if (abort_expected == 0)
					abort_run("sys_abort on a well formed system header");
				abort_expected--;
			end
		end
	end

	task automatic send_bit(input logic b);
		int gaps;
		gaps = 0;
		if (($random(seed) & 3) == 0)
			gaps = 1 + ($random(seed) & 7);
		repeat (gaps) begin
			@(posedge clk);
			#1;
			en = 1'b0;
			stream_bit = 1'($random(seed)); // noise while en is low
		end
		@(posedge clk);
		#1;
		en = 1'b1;
		stream_bit = b;
	endtask

	task automatic send_stream();
		byte_t b;
		int i;
		while (tx_q.size() != 0) begin
			b = tx_q.pop_front();
			for (i = 7; i >= 0; i--)
				send_bit(b[i]);
		end
		@(posedge clk);
		#1;
		en = 1'b0;
	endtask

	// same bit pattern on stream_bit, but with en held low throughout
	task automatic send_masked();
		byte_t b;
		int i;
		while (tx_q.size() != 0) begin
			b = tx_q.pop_front();
			for (i = 7; i >= 0; i--) begin
				@(posedge clk);
				#1;
				en = 1'b0;
				stream_bit = b[i];
			end
		end
	endtask

	task automatic wait_drained(input int limit);
		int cycles;
		cycles = 0;
		while (pending() != 0 && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (pending() != 0)
			abort_run("timeout waiting for the expected header results");
	endtask

	task automatic push_code(input byte_t code);
		tx_q.push_back(8'h00);
		tx_q.push_back(8'h00);
		tx_q.push_back(8'h01);
		tx_q.push_back(code);
	endtask

	// nonzero bytes never start a prefix
	task automatic push_filler(input int n);
		repeat (n) tx_q.push_back(8'($random(seed)) | 8'h01);
	endtask

	task automatic push_pack(input scr_t s, input rate_t m, input logic bad_marker);
		push_code(8'hBA);
		tx_q.push_back({4'b0010, s[32:30], 1'b1});
		tx_q.push_back(s[29:22]);
		tx_q.push_back({s[21:15], ~bad_marker});
		tx_q.push_back(s[14:7]);
		tx_q.push_back({s[6:0], 1'b1});
		tx_q.push_back({1'b1, m[21:15]});
		tx_q.push_back(m[14:7]);
		tx_q.push_back({m[6:0], 1'b1});
		exp_scr_q.push_back(s);
		exp_mux_q.push_back(m);
		exp_mkr_q.push_back(bad_marker);
	endtask

	// mode 0 well formed, 1 length one byte long, 2 first stream id invalid
	task automatic push_sys(input rate_t r, input logic [5:0] a, input logic [4:0] v,
			input logic [3:0] f, input int n, input int mode);
		hdr_len_t len;
		stream_id_t id;
		logic sc;
		buf_size_t size;
		int i;
		len = 16'(6 + 3 * n + ((mode == 1) ? 1 : 0));
		push_code(8'hBB);
		tx_q.push_back(len[15:8]);
		tx_q.push_back(len[7:0]);
		tx_q.push_back({1'b1, r[21:15]});
		tx_q.push_back(r[14:7]);
		tx_q.push_back({r[6:0], 1'b1});
		tx_q.push_back({a, f[3:2]});      // fixed, csps
		tx_q.push_back({f[1:0], 1'b1, v}); // audio lock, video lock
		tx_q.push_back(8'hFF);             // reserved
		exp_rate_q.push_back(r);
		exp_audio_q.push_back(a);
		exp_video_q.push_back(v);
		exp_flags_q.push_back(f);
		for (i = 0; i < n; i++) begin
			id = 8'($random(seed)) | 8'h80;
			if (mode == 2 && i == 0)
				id = id & 8'h7F;
			sc = 1'($random(seed));
			size = 13'($random(seed));
			tx_q.push_back(id);
			tx_q.push_back({2'b11, sc, size[12:8]});
			tx_q.push_back(size[7:0]);
			if (mode == 0) begin
				exp_id_q.push_back(id);
				exp_scale_q.push_back(sc);
				exp_size_q.push_back(size);
			end
		end
		if (mode == 1)
			tx_q.push_back(8'hFF); // the extra byte the length claims
		if (mode != 0)
			abort_expected++;
	endtask

	// 00 00 01 BA runs from the zero flag bytes into the entry's stream id
	task automatic push_sys_with_code(input rate_t r);
		logic sc;
		buf_size_t size;
		sc = 1'($random(seed));
		size = 13'($random(seed));
		push_code(8'hBB);
		tx_q.push_back(8'h00);
		tx_q.push_back(8'h09); // fixed part and one entry
		tx_q.push_back({1'b1, r[21:15]});
		tx_q.push_back(r[14:7]);
		tx_q.push_back({r[6:0], 1'b1});
		tx_q.push_back(8'h00);
		tx_q.push_back(8'h00); // video marker cleared too
		tx_q.push_back(8'h01);
		tx_q.push_back(8'hBA);
		tx_q.push_back({2'b11, sc, size[12:8]});
		tx_q.push_back(size[7:0]);
		exp_rate_q.push_back(r);
		exp_audio_q.push_back(6'd0);
		exp_video_q.push_back(5'd0);
		exp_flags_q.push_back(4'd0);
		exp_id_q.push_back(8'hBA);
		exp_scale_q.push_back(sc);
		exp_size_q.push_back(size);
	endtask

	initial begin
		scr_t s;
		rate_t m;
		int n;
		seed = 32'h2626_458f;
		reset = 1'b1;
		en = 1'b0;
		stream_bit = 1'b0;
		abort_expected = 0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		assert ({scr, mux_rate, marker_error, rate_bound, audio_bound, video_bound, sys_flags,
				entry_stream_id, entry_buf_scale, entry_buf_size} == '0)
			else abort_run("result outputs not zero after reset");
		assert ({pulse_dummy_free(pack_done, sys_done, entry_valid, sys_abort)} == 1'b0)
			else abort_run("pulse output high after reset");
		push_code(8'hBA);
		repeat (PACK_HEADER_BYTES) tx_q.push_back(8'hFF); // every marker set
		send_masked();
		repeat (20) @(posedge clk); // any pulse here is unexpected

		s = 33'({$random(seed), $random(seed)});
		m = 22'($random(seed));
		push_filler(3);
		push_pack(s, m, 1'b0);
		push_filler(2);
		push_pack(s, m, 1'b1); // one marker cleared
		send_stream();
		wait_drained(100);

		for (n = 0; n <= 4; n++) begin
			push_filler(2);
			push_sys(22'($random(seed)), 6'($random(seed)), 5'($random(seed)),
				4'($random(seed)), n, 0);
			send_stream();
			wait_drained(100);
		end

		push_filler(4);
		push_code(8'hE0);     // foreign code
		push_filler(3);
		tx_q.push_back(8'h00); // three zeros before 01
		push_pack(33'({$random(seed), $random(seed)}), 22'($random(seed)), 1'b0);
		tx_q.push_back(8'h00);
		tx_q.push_back(8'h00);
		push_code(8'hE0);
		push_code(8'h00);     // code byte 00 opens the next prefix
		push_sys(22'($random(seed)), 6'($random(seed)), 5'($random(seed)),
			4'($random(seed)), 2, 0);
		push_filler(2);
		send_stream();
		wait_drained(100);

		push_sys_with_code(22'($random(seed)));
		push_filler(3);
		push_sys(22'($random(seed)), 6'($random(seed)), 5'($random(seed)),
			4'($random(seed)), 1, 1);
		push_filler(3);
		push_sys(22'($random(seed)), 6'($random(seed)), 5'($random(seed)),
			4'($random(seed)), 2, 2);
		push_filler(3);
		push_pack(33'({$random(seed), $random(seed)}), 22'($random(seed)), 1'b0);
		push_sys(22'($random(seed)), 6'($random(seed)), 5'($random(seed)),
			4'($random(seed)), 3, 0);
		send_stream();
		wait_drained(100);

		repeat (10) @(posedge clk);
		if (pending() == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			abort_run("expected results still outstanding at end of run");
		end
	end

	function automatic logic pulse_dummy_free(input logic a, input logic b, input logic c,
			input logic d);
		return a | b | c | d;
	endfunction

endmodule

// File: mpeg_sys_parser.f
hdl/mpeg_sys_pkg.sv
hdl/serial_byte_assembler.sv
hdl/start_code_detector.sv
hdl/pack_header_parser.sv
hdl/system_header_parser.sv
hdl/mpeg_sys_parser.sv
sim/tb_mpeg_sys_parser.sv

// File: Makefile
# Verilator build, run and lint for the MPEG-1 system header parser.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TB_TOP    ?= tb_mpeg_sys_parser
DUT_TOP   ?= mpeg_sys_parser
FILELIST  ?= mpeg_sys_parser.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= ** PASS **

SOURCES := $(wildcard hdl/*.sv sim/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the testbench printed the pass message
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
